// ==== list.f ====
+incdir+logic
logic/scache_pkg.sv
logic/id_allocator.sv
logic/hash_table.sv
logic/lookup_pipeline.sv
logic/delete_queue.sv
logic/state_cache_top.sv
test/state_cache_asserts.sv
test/state_cache_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := state_cache_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/state_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scache_macros.svh"

module state_cache_tb;

    localparam int          CLK_HALF     = 20;
    localparam int          DRIVE_DLY    = 2;
    localparam int          RESET_CYCLES = 8;
    localparam int          WAIT_LIMIT   = 100;
    localparam logic [31:0] SEED         = 32'h4ea2ab2a;
    // Three resets with init walks of about 45 cycles each, under 100 lookup cycles
    localparam int TEST_CYCLES    = 400;
    localparam int TIMEOUT_CYCLES = 10 * TEST_CYCLES;

    logic                    clk;
    logic                    htable_srst;
    scache_pkg::lookup_req_t lookup_req;
    scache_pkg::del_req_t    del_req;
    scache_pkg::lookup_rsp_t lookup_rsp;
    logic                    del_credit;
    scache_pkg::stats_t      stats;
    logic [`SCACHE_ID_WID:0] fill;
    logic                    init_done;

    // Reference model of the cache
    int                           tracked [scache_pkg::key_t];
    logic [`SCACHE_NUM_SLOTS-1:0] slot_busy;
    logic [`SCACHE_NUM_IDS-1:0]   id_busy;
    scache_pkg::key_t             id_key [`SCACHE_NUM_IDS];
    scache_pkg::id_t              free_q [$];
    int                           model_req;
    int                           model_hit;
    int                           model_new;
    int                           model_fail;

    scache_pkg::key_t        stim_q [$];
    scache_pkg::lookup_rsp_t rsp_q [$];
    scache_pkg::key_t        coll_key;
    int                      errors;
    int                      checks;
    int                      cycle_cnt;

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    state_cache_top u_state_cache_top (
        .clk          (clk),
        .htable_srst  (htable_srst),
        .i_lookup     (lookup_req),
        .i_del        (del_req),
        .o_lookup_rsp (lookup_rsp),
        .o_del_credit (del_credit),
        .o_stats      (stats),
        .o_fill       (fill),
        .o_init_done  (init_done)
    );

    // Responses are collected away from the active edge
    always @(negedge clk) begin
        if (lookup_rsp.valid) begin
            rsp_q.push_back(lookup_rsp);
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, tests did not complete", cycle_cnt);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------
    // Checks and model
    // ------------------------------
    task automatic check_value(input string test, input string what, input int exp,
                               input int act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", test, what, exp, act);
        end
    endtask

    task automatic check_true(input string test, input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Test %s failed: %s", test, msg);
        end
    endtask

    // Every key bit lands on slot bit (position mod 5)
    function automatic logic [4:0] fold_key(input logic [15:0] key);
        logic [4:0] idx;
        idx = '0;
        for (int b = 0; b < 16; b++) begin
            idx[b % 5] = idx[b % 5] ^ key[b];
        end
        return idx;
    endfunction

    task automatic clear_model();
        tracked.delete();
        slot_busy = '0;
        id_busy   = '0;
        free_q.delete();
        for (int i = 0; i < `SCACHE_NUM_IDS; i++) begin
            free_q.push_back(scache_pkg::id_t'(i));
        end
        model_req  = 0;
        model_hit  = 0;
        model_new  = 0;
        model_fail = 0;
    endtask

    task automatic predict_lookup(input scache_pkg::key_t key,
                                  output scache_pkg::lookup_status_e st,
                                  output scache_pkg::id_t id);
        logic [4:0] idx;
        idx = fold_key(key);
        model_req++;
        if (tracked.exists(key)) begin
            st = scache_pkg::LS_HIT;
            id = scache_pkg::id_t'(tracked[key]);
            model_hit++;
        end else if (!slot_busy[idx] && free_q.size() > 0) begin
            st             = scache_pkg::LS_NEW;
            id             = free_q.pop_front();
            tracked[key]   = int'(id);
            slot_busy[idx] = 1'b1;
            id_busy[id]    = 1'b1;
            id_key[id]     = key;
            model_new++;
        end else begin
            st = scache_pkg::LS_FAIL;
            id = '0;
            model_fail++;
        end
    endtask

    task automatic model_delete(input scache_pkg::id_t id);
        if (id_busy[id]) begin
            tracked.delete(id_key[id]);
            slot_busy[fold_key(id_key[id])] = 1'b0;
            id_busy[id] = 1'b0;
            free_q.push_back(id);
        end
    endtask

    task automatic check_stats(input string test);
        check_value(test, "req count", model_req, int'(stats.req_cnt));
        check_value(test, "hit count", model_hit, int'(stats.hit_cnt));
        check_value(test, "new count", model_new, int'(stats.new_cnt));
        check_value(test, "fail count", model_fail, int'(stats.fail_cnt));
        check_value(test, "fill", tracked.num(), int'(fill));
    endtask

    // ------------------------------
    // Drivers
    // ------------------------------
    task automatic apply_reset();
        @(posedge clk);
        #DRIVE_DLY;
        htable_srst = 1'b1;
        lookup_req  = '0;
        del_req     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        htable_srst = 1'b0;
        clear_model();
    endtask

    task automatic wait_init(input string test);
        int n;
        n = 0;
        while (!init_done && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        check_true(test, init_done === 1'b1, "init_done did not rise after reset");
    endtask

    // Sends stim_q in back-to-back cycles and compares every response
    task automatic run_burst(input string test);
        scache_pkg::lookup_status_e exp_st [$];
        scache_pkg::id_t            exp_id [$];
        scache_pkg::lookup_status_e st;
        scache_pkg::id_t            id;
        scache_pkg::lookup_rsp_t    rsp;
        int                         n;
        rsp_q.delete();
        foreach (stim_q[i]) begin
            predict_lookup(stim_q[i], st, id);
            exp_st.push_back(st);
            exp_id.push_back(id);
            @(posedge clk);
            #DRIVE_DLY;
            lookup_req.valid = 1'b1;
            lookup_req.key   = stim_q[i];
        end
        @(posedge clk);
        #DRIVE_DLY;
        lookup_req.valid = 1'b0;
        n = 0;
        while (rsp_q.size() < stim_q.size() && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        check_true(test, rsp_q.size() == stim_q.size(), "lookup responses missing");
        while (rsp_q.size() > 0 && exp_st.size() > 0) begin
            rsp = rsp_q.pop_front();
            check_value(test, "status", int'(exp_st.pop_front()), int'(rsp.status));
            check_value(test, "id", int'(exp_id.pop_front()), int'(rsp.id));
        end
        stim_q.delete();
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_init_and_idle();
        apply_reset();
        check_value("init", "init_done in reset", 0, int'(init_done));
        rsp_q.delete();
        // Early lookup gets dropped
        @(posedge clk);
        #DRIVE_DLY;
        lookup_req.valid = 1'b1;
        lookup_req.key   = 16'h0abc;
        @(posedge clk);
        #DRIVE_DLY;
        lookup_req.valid = 1'b0;
        wait_init("init");
        check_value("init", "early responses", 0, rsp_q.size());
        check_stats("init");
    endtask

    task automatic test_hit_after_new();
        stim_q.push_back(16'h1234);
        stim_q.push_back(16'h1234);
        run_burst("hit");
        stim_q.push_back(16'h1234);
        run_burst("hit");
        check_stats("hit");
    endtask

    task automatic test_fill_table();
        apply_reset();
        wait_init("fill");
        for (int i = 0; i <= `SCACHE_NUM_IDS; i++) begin
            stim_q.push_back(16'h3c00 | 16'(i));
        end
        run_burst("fill");
        check_value("fill", "fill count", `SCACHE_NUM_IDS, int'(fill));
    endtask

    task automatic test_collision();
        logic [31:0]      rnd;
        scache_pkg::key_t other;
        apply_reset();
        wait_init("collision");
        rnd      = $urandom;
        coll_key = rnd[15:0];
        rnd      = $urandom;
        other    = rnd[15:0];
        // Low slice adjusted so both keys fold to one slot
        other[4:0] = other[4:0] ^ fold_key(other) ^ fold_key(coll_key);
        // Bits 0 and 5 share slot bit 0
        if (other == coll_key) begin
            other = other ^ 16'h0021;
        end
        stim_q.push_back(coll_key);
        stim_q.push_back(other);
        run_burst("collision");
    endtask

    task automatic test_delete();
        scache_pkg::id_t id;
        int              fill_before;
        int              n;
        id          = scache_pkg::id_t'(tracked[coll_key]);
        fill_before = int'(fill);
        check_value("delete", "fill before delete", tracked.num(), fill_before);
        @(posedge clk);
        #DRIVE_DLY;
        del_req.valid = 1'b1;
        del_req.id    = id;
        model_delete(id);
        @(posedge clk);
        #DRIVE_DLY;
        del_req.valid = 1'b0;
        n = 0;
        while (!del_credit && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        check_true("delete", del_credit === 1'b1, "delete credit did not come back");
        check_value("delete", "fill after delete", fill_before - 1, int'(fill));
        stim_q.push_back(coll_key);
        run_burst("delete");
        check_value("delete", "fill after insert", fill_before, int'(fill));
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        htable_srst = 1'b1;
        lookup_req  = '0;
        del_req     = '0;
        void'($urandom(SEED));
        test_init_and_idle();
        test_hit_after_new();
        test_fill_table();
        test_collision();
        test_delete();
        check_stats("stats");
        errors += u_state_cache_top.u_asserts.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 u_state_cache_top.u_asserts.fail_cnt);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/state_cache_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scache_macros.svh"

module state_cache_asserts (
    input wire                           clk,
    input wire                           htable_srst,
    input wire scache_pkg::lookup_req_t  i_lookup,
    input wire scache_pkg::del_req_t     i_del,
    input wire scache_pkg::lookup_rsp_t  i_lookup_rsp,
    input wire                           i_del_credit,
    input wire                           i_init_done
);

    int outstanding;
    int fail_cnt = 0;

    // Deletes issued and not yet credited
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            outstanding <= 0;
        end else if (i_del.valid && !i_del_credit) begin
            outstanding <= outstanding + 1;
        end else if (!i_del.valid && i_del_credit) begin
            outstanding <= outstanding - 1;
        end
    end

    // ------------------------------
    // Lookup timing and credits
    // ------------------------------
    // Registered two edges after accept, so seen by the sample one edge later
    rsp_latency: assert property (@(posedge clk) disable iff (htable_srst)
        (i_lookup.valid && i_init_done) |-> ##3 i_lookup_rsp.valid)
        else begin
            fail_cnt++;
            $error("lookup response missing two cycles after accept");
        end

    del_credit_limit: assert property (@(posedge clk) disable iff (htable_srst)
        outstanding <= `SCACHE_DEL_CREDITS)
        else begin
            fail_cnt++;
            $error("more deletes outstanding than credits");
        end

    quiet_before_init: assert property (@(posedge clk) disable iff (htable_srst)
        !i_init_done |-> !i_lookup_rsp.valid)
        else begin
            fail_cnt++;
            $error("lookup response before init_done");
        end

endmodule

bind state_cache_top state_cache_asserts u_asserts (
    .clk          (clk),
    .htable_srst  (htable_srst),
    .i_lookup     (i_lookup),
    .i_del        (i_del),
    .i_lookup_rsp (o_lookup_rsp),
    .i_del_credit (o_del_credit),
    .i_init_done  (o_init_done)
);

`default_nettype wire

// ==== logic/state_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scache_macros.svh"

module state_cache_top (
    input  wire                            clk,
    input  wire                            htable_srst,
    input  wire  scache_pkg::lookup_req_t  i_lookup,
    input  wire  scache_pkg::del_req_t     i_del,
    output scache_pkg::lookup_rsp_t        o_lookup_rsp,
    output logic                           o_del_credit,
    output scache_pkg::stats_t             o_stats,
    output logic [`SCACHE_ID_WID:0]        o_fill,
    output logic                           o_init_done
);

    scache_pkg::idx_t       rd_idx;
    scache_pkg::tbl_entry_t rd_entry;
    scache_pkg::idx_t       rd_idx_del;
    scache_pkg::tbl_entry_t rd_entry_del;
    scache_pkg::tbl_wr_t    ins_wr;
    scache_pkg::tbl_wr_t    del_wr;
    logic                   alloc;
    scache_pkg::key_t       alloc_key;
    logic                   avail;
    scache_pkg::id_t        alloc_id;
    scache_pkg::del_req_t   free_req;
    scache_pkg::key_t       free_key;
    logic                   free_hit;
    logic                   tbl_ready;
    logic                   alloc_ready;

    lookup_pipeline u_lookup_pipeline (
        .clk           (clk),
        .htable_srst   (htable_srst),
        .i_lookup      (i_lookup),
        .o_lookup_rsp  (o_lookup_rsp),
        .o_rd_idx      (rd_idx),
        .i_rd_entry    (rd_entry),
        .o_wr          (ins_wr),
        .o_alloc       (alloc),
        .o_alloc_key   (alloc_key),
        .i_avail       (avail),
        .i_alloc_id    (alloc_id),
        .i_tbl_ready   (tbl_ready),
        .i_alloc_ready (alloc_ready),
        .o_stats       (o_stats),
        .o_init_done   (o_init_done)
    );

    hash_table u_hash_table (
        .clk         (clk),
        .htable_srst (htable_srst),
        .i_rd_idx    (rd_idx),
        .o_rd_entry  (rd_entry),
        .i_rd_idx2   (rd_idx_del),
        .o_rd_entry2 (rd_entry_del),
        .i_wr        (ins_wr),
        .i_wr_del    (del_wr),
        .o_ready     (tbl_ready)
    );

    id_allocator u_id_allocator (
        .clk         (clk),
        .htable_srst (htable_srst),
        .i_alloc     (alloc),
        .i_alloc_key (alloc_key),
        .o_avail     (avail),
        .o_alloc_id  (alloc_id),
        .i_free      (free_req),
        .o_free_key  (free_key),
        .o_free_hit  (free_hit),
        .o_fill      (o_fill),
        .o_ready     (alloc_ready)
    );

    // Insert write also marks the cycle as busy for the delete path
    delete_queue u_delete_queue (
        .clk             (clk),
        .htable_srst     (htable_srst),
        .i_del           (i_del),
        .o_del_credit    (o_del_credit),
        .i_ins_busy      (ins_wr.en),
        .o_free          (free_req),
        .i_free_key      (free_key),
        .i_free_hit      (free_hit),
        .i_rd_entry_slot (rd_entry_del),
        .o_rd_idx_del    (rd_idx_del),
        .o_wr_del        (del_wr)
    );

endmodule

`default_nettype wire

// ==== logic/delete_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scache_macros.svh"

module delete_queue (
    input  wire                          clk,
    input  wire                          htable_srst,
    input  wire  scache_pkg::del_req_t   i_del,
    output logic                         o_del_credit,
    input  wire                          i_ins_busy,
    output scache_pkg::del_req_t         o_free,
    input  wire  scache_pkg::key_t       i_free_key,
    input  wire                          i_free_hit,
    input  wire  scache_pkg::tbl_entry_t i_rd_entry_slot,
    output scache_pkg::idx_t             o_rd_idx_del,
    output scache_pkg::tbl_wr_t          o_wr_del
);

    localparam int PTR_WID = $clog2(`SCACHE_DEL_CREDITS) + 1;

    typedef enum logic [1:0] {
        DQ_IDLE,
        DQ_READ,
        DQ_CHECK
    } dq_state_e;

    scache_pkg::id_t    q_mem [`SCACHE_DEL_CREDITS];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic               q_empty;
    dq_state_e          state;
    scache_pkg::id_t    del_id;
    logic               del_hit;
    scache_pkg::idx_t   del_idx;
    logic               issue;
    logic               clr_needed;
    logic               done;

    // Credits keep the queue from overflowing
    always_ff @(posedge clk) begin
        if (i_del.valid) begin
            q_mem[wr_ptr[PTR_WID-2:0]] <= i_del.id;
        end
    end

    assign q_empty = (wr_ptr == rd_ptr);

    // Free the oldest ID only while no insert owns the write port
    assign issue       = (state == DQ_IDLE) && !q_empty && !i_ins_busy;
    assign o_free.valid = issue;
    assign o_free.id    = q_mem[rd_ptr[PTR_WID-2:0]];

    // Slot must still hold the freed ID
    assign clr_needed = del_hit && i_rd_entry_slot.valid && (i_rd_entry_slot.id == del_id);
    assign done       = (state == DQ_CHECK) && (!clr_needed || !i_ins_busy);

    assign o_rd_idx_del   = del_idx;
    assign o_wr_del.en    = (state == DQ_CHECK) && clr_needed && !i_ins_busy;
    assign o_wr_del.idx   = del_idx;
    assign o_wr_del.entry = '0;

    // ------------------------------
    // Delete FSM and queue pointers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            state        <= DQ_IDLE;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            o_del_credit <= 1'b0;
        end else begin
            o_del_credit <= done;
            if (i_del.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            case (state)
                DQ_IDLE: begin
                    if (issue) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        state  <= DQ_READ;
                    end
                end
                DQ_READ:  state <= DQ_CHECK;
                DQ_CHECK: begin
                    if (done) begin
                        state <= DQ_IDLE;
                    end
                end
                default:  state <= DQ_IDLE;
            endcase
        end
    end

    // Context of the delete in flight
    always_ff @(posedge clk) begin
        if (issue) begin
            del_id  <= o_free.id;
            del_hit <= i_free_hit;
            del_idx <= scache_pkg::slot_hash(i_free_key);
        end
    end

endmodule

`default_nettype wire

// ==== logic/lookup_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module lookup_pipeline (
    input  wire                            clk,
    input  wire                            htable_srst,
    input  wire  scache_pkg::lookup_req_t  i_lookup,
    output scache_pkg::lookup_rsp_t        o_lookup_rsp,
    output scache_pkg::idx_t               o_rd_idx,
    input  wire  scache_pkg::tbl_entry_t   i_rd_entry,
    output scache_pkg::tbl_wr_t            o_wr,
    output logic                           o_alloc,
    output scache_pkg::key_t               o_alloc_key,
    input  wire                            i_avail,
    input  wire  scache_pkg::id_t          i_alloc_id,
    input  wire                            i_tbl_ready,
    input  wire                            i_alloc_ready,
    output scache_pkg::stats_t             o_stats,
    output logic                           o_init_done
);

    logic                       s1_valid;
    scache_pkg::key_t           s1_key;
    logic                       s2_valid;
    scache_pkg::key_t           s2_key;
    scache_pkg::idx_t           s2_idx;
    logic                       key_match;
    scache_pkg::lookup_status_e status;

    always_ff @(posedge clk) begin
        if (htable_srst) begin
            o_init_done <= 1'b0;
        end else begin
            o_init_done <= i_tbl_ready && i_alloc_ready;
        end
    end

    // ------------------------------
    // Stage 1 and 2 registers
    // ------------------------------
    // Requests before init_done are dropped here
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= i_lookup.valid && o_init_done;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_key <= i_lookup.key;
        s2_key <= s1_key;
        s2_idx <= o_rd_idx;
    end

    assign o_rd_idx = scache_pkg::slot_hash(s1_key);

    // ------------------------------
    // Classify the slot contents
    // ------------------------------
    always_comb begin
        key_match = i_rd_entry.valid && (i_rd_entry.key == s2_key);
        if (!s2_valid) begin
            status = scache_pkg::LS_NONE;
        end else if (key_match) begin
            status = scache_pkg::LS_HIT;
        end else if (!i_rd_entry.valid && i_avail) begin
            status = scache_pkg::LS_NEW;
        end else begin
            // Collision or no free ID
            status = scache_pkg::LS_FAIL;
        end
    end

    // Insert pops the allocator and writes the slot at the same edge
    assign o_alloc     = (status == scache_pkg::LS_NEW);
    assign o_alloc_key = s2_key;

    always_comb begin
        o_wr.en          = o_alloc;
        o_wr.idx         = s2_idx;
        o_wr.entry.valid = 1'b1;
        o_wr.entry.key   = s2_key;
        o_wr.entry.id    = i_alloc_id;
    end

    always_ff @(posedge clk) begin
        if (htable_srst) begin
            o_lookup_rsp <= '0;
        end else begin
            o_lookup_rsp.valid  <= s2_valid;
            o_lookup_rsp.status <= status;
            case (status)
                scache_pkg::LS_HIT: o_lookup_rsp.id <= i_rd_entry.id;
                scache_pkg::LS_NEW: o_lookup_rsp.id <= i_alloc_id;
                default:            o_lookup_rsp.id <= '0;
            endcase
        end
    end

    // Request, tracked-existing, tracked-new and not-tracked counts
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            o_stats <= '0;
        end else if (s2_valid) begin
            o_stats.req_cnt <= o_stats.req_cnt + 1'b1;
            case (status)
                scache_pkg::LS_HIT:  o_stats.hit_cnt  <= o_stats.hit_cnt + 1'b1;
                scache_pkg::LS_NEW:  o_stats.new_cnt  <= o_stats.new_cnt + 1'b1;
                default:             o_stats.fail_cnt <= o_stats.fail_cnt + 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/hash_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scache_macros.svh"

module hash_table (
    input  wire                          clk,
    input  wire                          htable_srst,
    input  wire  scache_pkg::idx_t       i_rd_idx,
    output scache_pkg::tbl_entry_t       o_rd_entry,
    input  wire  scache_pkg::idx_t       i_rd_idx2,
    output scache_pkg::tbl_entry_t       o_rd_entry2,
    input  wire  scache_pkg::tbl_wr_t    i_wr,
    input  wire  scache_pkg::tbl_wr_t    i_wr_del,
    output logic                         o_ready
);

    scache_pkg::tbl_entry_t  mem [`SCACHE_NUM_SLOTS];
    scache_pkg::init_state_e state;
    scache_pkg::idx_t        clr_idx;
    scache_pkg::tbl_wr_t     wr_sel;

    // ------------------------------
    // Clear walk over all slots
    // ------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            state   <= scache_pkg::ST_INIT;
            clr_idx <= '0;
        end else if (state == scache_pkg::ST_INIT) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == scache_pkg::idx_t'(`SCACHE_NUM_SLOTS - 1)) begin
                state <= scache_pkg::ST_RUN;
            end
        end
    end

    assign o_ready = (state == scache_pkg::ST_RUN);

    // Single write port, inserts take priority over deletes
    always_comb begin
        wr_sel = i_wr.en ? i_wr : i_wr_del;
        if (!o_ready) begin
            wr_sel.en = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!o_ready) begin
            mem[clr_idx] <= '0;
        end else if (wr_sel.en) begin
            mem[wr_sel.idx] <= wr_sel.entry;
        end
    end

    // Read data with bypass of a write to the same slot in the same cycle
    function automatic scache_pkg::tbl_entry_t read_fwd(input scache_pkg::idx_t idx);
        if (wr_sel.en && (wr_sel.idx == idx)) begin
            return wr_sel.entry;
        end
        return mem[idx];
    endfunction

    // ------------------------------
    // Synchronous read ports
    // ------------------------------
    always_ff @(posedge clk) begin
        o_rd_entry  <= read_fwd(i_rd_idx);
        o_rd_entry2 <= read_fwd(i_rd_idx2);
    end

endmodule

`default_nettype wire

// ==== logic/id_allocator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scache_macros.svh"

module id_allocator (
    input  wire                          clk,
    input  wire                          htable_srst,
    input  wire                          i_alloc,
    input  wire  scache_pkg::key_t       i_alloc_key,
    output logic                         o_avail,
    output scache_pkg::id_t              o_alloc_id,
    input  wire  scache_pkg::del_req_t   i_free,
    output scache_pkg::key_t             o_free_key,
    output logic                         o_free_hit,
    output logic [`SCACHE_ID_WID:0]      o_fill,
    output logic                         o_ready
);

    localparam int PTR_WID = `SCACHE_ID_WID + 1;

    scache_pkg::id_t            free_mem [`SCACHE_NUM_IDS];
    scache_pkg::key_t           key_mem  [`SCACHE_NUM_IDS];
    logic [`SCACHE_NUM_IDS-1:0] in_use;
    logic [PTR_WID-1:0]         wr_ptr;
    logic [PTR_WID-1:0]         rd_ptr;
    scache_pkg::init_state_e    state;
    scache_pkg::id_t            init_id;
    logic                       push;
    scache_pkg::id_t            push_id;
    logic                       pop;

    // ------------------------------
    // Free list init walk
    // ------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            state   <= scache_pkg::ST_INIT;
            init_id <= '0;
        end else if (state == scache_pkg::ST_INIT) begin
            init_id <= init_id + 1'b1;
            if (init_id == scache_pkg::id_t'(`SCACHE_NUM_IDS - 1)) begin
                state <= scache_pkg::ST_RUN;
            end
        end
    end

    assign o_ready = (state == scache_pkg::ST_RUN);

    // Walk pushes IDs 0..15, later only freed IDs go back to the tail
    assign push    = !o_ready || o_free_hit;
    assign push_id = o_ready ? i_free.id : init_id;
    assign pop     = i_alloc && o_avail;

    assign o_avail    = o_ready && (wr_ptr != rd_ptr);
    assign o_alloc_id = free_mem[rd_ptr[PTR_WID-2:0]];

    // Free response is combinational from the requested ID
    assign o_free_key = key_mem[i_free.id];
    assign o_free_hit = o_ready && i_free.valid && in_use[i_free.id];

    // ------------------------------
    // Pointers, in-use bits, fill
    // ------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            in_use <= '0;
            o_fill <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr             <= rd_ptr + 1'b1;
                in_use[o_alloc_id] <= 1'b1;
            end
            if (o_free_hit) begin
                in_use[i_free.id] <= 1'b0;
            end
            case ({pop, o_free_hit})
                2'b10:   o_fill <= o_fill + 1'b1;
                2'b01:   o_fill <= o_fill - 1'b1;
                default: o_fill <= o_fill;
            endcase
        end
    end

    // Free list storage and the key of every allocated ID
    always_ff @(posedge clk) begin
        if (push) begin
            free_mem[wr_ptr[PTR_WID-2:0]] <= push_id;
        end
        if (pop) begin
            key_mem[o_alloc_id] <= i_alloc_key;
        end
    end

endmodule

`default_nettype wire

// ==== logic/scache_pkg.sv ====
`default_nettype none

`include "scache_macros.svh"

package scache_pkg;

    typedef logic [`SCACHE_KEY_WID-1:0] key_t;
    typedef logic [`SCACHE_ID_WID-1:0]  id_t;
    typedef logic [`SCACHE_IDX_WID-1:0] idx_t;

    // Lookup outcome
    typedef enum logic [1:0] {
        LS_NONE,
        LS_HIT,
        LS_NEW,
        LS_FAIL
    } lookup_status_e;

    // Init walk of the table and the free list
    typedef enum logic {
        ST_INIT,
        ST_RUN
    } init_state_e;

    typedef struct packed {
        logic valid;
        key_t key;
    } lookup_req_t;

    typedef struct packed {
        logic           valid;
        lookup_status_e status;
        id_t            id;
    } lookup_rsp_t;

    typedef struct packed {
        logic valid;
        key_t key;
        id_t  id;
    } tbl_entry_t;

    typedef struct packed {
        logic       en;
        idx_t       idx;
        tbl_entry_t entry;
    } tbl_wr_t;

    typedef struct packed {
        logic valid;
        id_t  id;
    } del_req_t;

    typedef struct packed {
        logic [`SCACHE_CNT_WID-1:0] req_cnt;
        logic [`SCACHE_CNT_WID-1:0] hit_cnt;
        logic [`SCACHE_CNT_WID-1:0] new_cnt;
        logic [`SCACHE_CNT_WID-1:0] fail_cnt;
    } stats_t;

    // Folding hash, three 5-bit slices and the top bit
    function automatic idx_t slot_hash(input key_t key);
        return key[4:0] ^ key[9:5] ^ key[14:10] ^ idx_t'(key[15]);
    endfunction

endpackage

`default_nettype wire

// ==== logic/scache_macros.svh ====
`ifndef SCACHE_MACROS_SVH
`define SCACHE_MACROS_SVH

// ------------------------------
// Datapath widths
// ------------------------------

// Flow key presented by a lookup
`define SCACHE_KEY_WID 16

// State ID, one per tracked flow
`define SCACHE_ID_WID 4

// Slot index of the direct-mapped table
`define SCACHE_IDX_WID 5

// Width of each statistics counter
`define SCACHE_CNT_WID 16

// ------------------------------
// Derived sizes and flow control
// ------------------------------

`define SCACHE_NUM_IDS (1 << `SCACHE_ID_WID)
`define SCACHE_NUM_SLOTS (1 << `SCACHE_IDX_WID)

// Credits owned by the delete requester, also the delete queue depth
`define SCACHE_DEL_CREDITS 4

`endif
